// File: design/crc_defines.svh
// CRC-16 constants and register map; polynomial is fixed, addresses assume a 3-bit register port
`ifndef CRC_DEFINES_SVH
`define CRC_DEFINES_SVH

// generator polynomial in MSB-first form
`define CRC_POLY 16'h8005
`define CRC_W 16

// frame counters saturate at all ones
`define CNT_W 16

`define REG_CTRL     3'd0
`define REG_INJ_IDX  3'd1
`define REG_INJ_MASK 3'd2
`define REG_GOOD_CNT 3'd3
`define REG_BAD_CNT  3'd4

`endif

// File: design/crc_pkg.sv
// shared link types; CRC width comes from crc_defines.svh and must stay a multiple of 8
`include "crc_defines.svh"

package crc_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [`CRC_W-1:0] crc_t;

    // fault injection setup whose index counts payload and CRC bytes from 0
    typedef struct packed {
        logic       enable;
        logic [7:0] index;
        byte_t      mask;
    } inj_cfg_t;

    // one result per received frame
    typedef struct packed {
        logic crc_ok;
        crc_t calc_crc;
        crc_t rx_crc;
    } frame_status_t;

endpackage

// File: design/byte_stream_if.sv
// valid/ready stream; source holds valid, data and last stable until ready is seen
`timescale 1ns/1ns

interface byte_stream_if #(
    parameter type T = logic [7:0]
);
    logic valid;
    logic ready;
    logic last;
    T     data;

    modport src (
        output valid, data, last,
        input  ready
    );

    modport dst (
        input  valid, data, last,
        output ready
    );

endinterface

// File: design/crc16_engine.sv
// byte-per-cycle CRC-16, init 0, no final XOR, bits of each byte taken LSB first; clear wins over feed
`timescale 1ns/1ns
`include "crc_defines.svh"

module crc16_engine import crc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  feed,
    input  byte_t data,
    output crc_t  crc
);

    crc_t       crc_q;
    crc_t       crc_mid;
    crc_t       crc_nxt;
    crc_t       nib_lut [16];
    logic [3:0] idx_lo;
    logic [3:0] idx_hi;

    // remainder of a nibble placed at the top of the register and shifted out bit by bit
    function automatic crc_t nib_entry(input logic [3:0] k);
        crc_t c;
        c = {k, {(`CRC_W-4){1'b0}}};
        for (int i = 0; i < 4; i++) begin
            if (c[`CRC_W-1]) begin
                c = {c[`CRC_W-2:0], 1'b0} ^ `CRC_POLY;
            end else begin
                c = {c[`CRC_W-2:0], 1'b0};
            end
        end
        return c;
    endfunction

    // bit 0 of the byte enters first, so it meets the register MSB
    function automatic logic [3:0] nib_rev(input logic [3:0] n);
        return {n[0], n[1], n[2], n[3]};
    endfunction

    for (genvar k = 0; k < 16; k++) begin : g_lut
        assign nib_lut[k] = nib_entry(4'(k));
    end

    always_comb begin
        // low nibble then high nibble in the same cycle
        idx_lo  = crc_q[`CRC_W-1 -: 4] ^ nib_rev(data[3:0]);
        crc_mid = {crc_q[`CRC_W-5:0], 4'b0000} ^ nib_lut[idx_lo];
        idx_hi  = crc_mid[`CRC_W-1 -: 4] ^ nib_rev(data[7:4]);
        crc_nxt = {crc_mid[`CRC_W-5:0], 4'b0000} ^ nib_lut[idx_hi];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= '0;
        end else if (clear) begin
            crc_q <= '0;
        end else if (feed) begin
            crc_q <= crc_nxt;
        end
    end

    assign crc = crc_q;

endmodule

// File: design/crc_tx_framer.sv
// appends CRC high then low byte to each frame; payload passes through combinationally
`timescale 1ns/1ns

module crc_tx_framer import crc_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    output logic          in_ready,
    input  byte_t         in_data,
    input  logic          in_last,
    byte_stream_if.src    out
);

    typedef enum logic [1:0] {
        S_PAYLOAD,
        S_CRC_HI,
        S_CRC_LO
    } state_t;

    state_t state_q;
    logic   active_q;
    logic   pay_fire;
    logic   out_fire;
    crc_t   crc;

    // holds the input closed during reset and for the first edge after it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    always_comb begin
        in_ready  = 1'b0;
        out.valid = 1'b1;
        out.data  = in_data;
        out.last  = 1'b0;
        case (state_q)
            S_PAYLOAD: begin
                in_ready  = active_q && out.ready;
                out.valid = active_q && in_valid;
            end
            S_CRC_HI: out.data = crc[15:8];
            default: begin
                out.data = crc[7:0];
                out.last = 1'b1;
            end
        endcase
    end

    assign out_fire = out.valid && out.ready;
    assign pay_fire = out_fire && (state_q == S_PAYLOAD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_PAYLOAD;
        end else if (out_fire) begin
            case (state_q)
                S_PAYLOAD: if (in_last) state_q <= S_CRC_HI;
                S_CRC_HI:  state_q <= S_CRC_LO;
                default:   state_q <= S_PAYLOAD;
            endcase
        end
    end

    // crc stays frozen across both trailer beats
    crc16_engine u_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (out_fire && (state_q == S_CRC_LO)),
        .feed  (pay_fire),
        .data  (in_data),
        .crc   (crc)
    );

endmodule

// File: design/link_fault_injector.sv
// one-deep pipeline register; position counter saturates at 255 so long frames never hit a small index twice
`timescale 1ns/1ns

module link_fault_injector import crc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  inj_cfg_t   cfg,
    byte_stream_if.dst in,
    byte_stream_if.src out
);

    logic       valid_q;
    logic       last_q;
    byte_t      data_q;
    logic [7:0] pos_q;
    logic       in_fire;
    logic       hit;

    // take a new beat when empty or when the held one leaves
    assign in.ready = !valid_q || out.ready;
    assign in_fire  = in.valid && in.ready;
    assign hit      = cfg.enable && (pos_q == cfg.index);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            pos_q   <= '0;
        end else begin
            if (in_fire) begin
                valid_q <= 1'b1;
                if (in.last) begin
                    pos_q <= '0;
                end else if (pos_q != 8'hff) begin
                    pos_q <= pos_q + 8'd1;
                end
            end else if (out.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            data_q <= hit ? (in.data ^ cfg.mask) : in.data;
            last_q <= in.last;
        end
    end

    assign out.valid = valid_q;
    assign out.data  = data_q;
    assign out.last  = last_q;

endmodule

// File: design/crc_rx_checker.sv
// last two bytes of a frame are taken as the CRC, high byte first; input stalls while a status waits
`timescale 1ns/1ns

module crc_rx_checker import crc_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    byte_stream_if.dst    in,
    output logic          status_valid,
    input  logic          status_ready,
    output frame_status_t status,
    output logic          frame_done
);

    byte_t      hold0_q;
    byte_t      hold1_q;
    logic [1:0] held_q;
    logic       pend_q;
    logic       short_q;
    crc_t       rx_crc_q;
    crc_t       calc_crc;
    logic       in_fire;
    logic       done;

    assign in.ready = !pend_q;
    assign in_fire  = in.valid && in.ready;
    assign done     = pend_q && status_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q  <= '0;
            pend_q  <= 1'b0;
            short_q <= 1'b0;
        end else begin
            if (in_fire) begin
                if (in.last) begin
                    held_q  <= '0;
                    pend_q  <= 1'b1;
                    short_q <= (held_q != 2'd2);
                end else if (held_q != 2'd2) begin
                    held_q <= held_q + 2'd1;
                end
            end else if (done) begin
                pend_q <= 1'b0;
            end
        end
    end

    // hold1 is the older byte of the two-byte delay line
    always_ff @(posedge clk) begin
        if (in_fire) begin
            hold0_q <= in.data;
            hold1_q <= hold0_q;
            if (in.last) begin
                rx_crc_q <= {hold0_q, in.data};
            end
        end
    end

    // a byte enters the engine only once two more have followed it
    crc16_engine u_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (done),
        .feed  (in_fire && (held_q == 2'd2)),
        .data  (hold1_q),
        .crc   (calc_crc)
    );

    assign status_valid    = pend_q;
    assign status.calc_crc = calc_crc;
    assign status.rx_crc   = rx_crc_q;
    assign status.crc_ok   = !short_q && (calc_crc == rx_crc_q);
    assign frame_done      = done;

endmodule

// File: design/crc_link_regs.sv
// simple write/read port, combinational readback; counters are read-only and saturate
`timescale 1ns/1ns
`include "crc_defines.svh"

module crc_link_regs import crc_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             reg_we,
    input  logic [2:0]       reg_addr,
    input  logic [`CNT_W-1:0] reg_wdata,
    output logic [`CNT_W-1:0] reg_rdata,
    output inj_cfg_t         cfg,
    input  logic             frame_done,
    input  logic             frame_ok
);

    logic             enable_q;
    logic [7:0]       index_q;
    byte_t            mask_q;
    logic [`CNT_W-1:0] good_q;
    logic [`CNT_W-1:0] bad_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
            index_q  <= '0;
            mask_q   <= '0;
            good_q   <= '0;
            bad_q    <= '0;
        end else begin
            if (reg_we) begin
                case (reg_addr)
                    `REG_CTRL:     enable_q <= reg_wdata[0];
                    `REG_INJ_IDX:  index_q  <= reg_wdata[7:0];
                    `REG_INJ_MASK: mask_q   <= reg_wdata[7:0];
                    default: ;
                endcase
            end
            // one update per consumed status
            if (frame_done) begin
                if (frame_ok && (good_q != '1)) begin
                    good_q <= good_q + 1'b1;
                end else if (!frame_ok && (bad_q != '1)) begin
                    bad_q <= bad_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (reg_addr)
            `REG_CTRL:     reg_rdata = {{(`CNT_W-1){1'b0}}, enable_q};
            `REG_INJ_IDX:  reg_rdata = {{(`CNT_W-8){1'b0}}, index_q};
            `REG_INJ_MASK: reg_rdata = {{(`CNT_W-8){1'b0}}, mask_q};
            `REG_GOOD_CNT: reg_rdata = good_q;
            `REG_BAD_CNT:  reg_rdata = bad_q;
            default:       reg_rdata = '0;
        endcase
    end

    assign cfg.enable = enable_q;
    assign cfg.index  = index_q;
    assign cfg.mask   = mask_q;

endmodule

// File: design/crc_link_top.sv
// link self-test top; injection happens after the TX CRC so corrupted frames are caught at RX
`timescale 1ns/1ns
`include "crc_defines.svh"

module crc_link_top import crc_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  byte_t            in_data,
    input  logic             in_last,
    output logic             status_valid,
    input  logic             status_ready,
    output logic             status_crc_ok,
    output crc_t             status_calc_crc,
    output crc_t             status_rx_crc,
    input  logic             reg_we,
    input  logic [2:0]       reg_addr,
    input  logic [`CNT_W-1:0] reg_wdata,
    output logic [`CNT_W-1:0] reg_rdata
);

    inj_cfg_t      cfg;
    frame_status_t status;
    logic          frame_done;

    byte_stream_if #(.T(byte_t)) tx_link ();
    byte_stream_if #(.T(byte_t)) rx_link ();

    crc_tx_framer u_framer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .in_last  (in_last),
        .out      (tx_link.src)
    );

    link_fault_injector u_injector (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .in    (tx_link.dst),
        .out   (rx_link.src)
    );

    crc_rx_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (rx_link.dst),
        .status_valid (status_valid),
        .status_ready (status_ready),
        .status       (status),
        .frame_done   (frame_done)
    );

    crc_link_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_we     (reg_we),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .cfg        (cfg),
        .frame_done (frame_done),
        .frame_ok   (status.crc_ok)
    );

    assign status_crc_ok   = status.crc_ok;
    assign status_calc_crc = status.calc_crc;
    assign status_rx_crc   = status.rx_crc;

endmodule

// File: test/crc_ref_model.svh
// bit-serial CRC-16 reference and frame scoreboard; include inside the testbench module only
`ifndef CRC_REF_MODEL_SVH
`define CRC_REF_MODEL_SVH

localparam logic [15:0] REF_POLY = 16'h8005;

// payload bytes of the current phase in frame order
logic [7:0]  pay_q [$];
int          len_q [$];

// expected statuses in frame order
logic [15:0] exp_calc_q [$];
logic [15:0] exp_rx_q [$];
logic        exp_ok_q [$];
int          good_exp = 0;
int          bad_exp = 0;

// one bit per step with bit 0 of each byte first, init 0 and no final XOR
function automatic logic [15:0] crc16_bitwise(input logic [7:0] bytes [$]);
    logic [15:0] c;
    logic        fb;
    c = 16'h0000;
    foreach (bytes[n]) begin
        for (int i = 0; i < 8; i++) begin
            fb = c[15] ^ bytes[n][i];
            c  = {c[14:0], 1'b0};
            if (fb) begin
                c = c ^ REF_POLY;
            end
        end
    end
    return c;
endfunction

// builds the frame as it looks on the wire, corrupts one position, then predicts the status
function automatic void predict_frame(input logic [7:0] frame [$], input logic en,
                                      input logic [7:0] idx, input logic [7:0] mask);
    logic [7:0]  wire_q [$];
    logic [7:0]  rx_pay [$];
    logic [15:0] clean;
    logic [15:0] calc;
    logic [15:0] rx;
    logic        ok;
    int          len;
    len   = frame.size();
    clean = crc16_bitwise(frame);
    wire_q = frame;
    wire_q.push_back(clean[15:8]);
    wire_q.push_back(clean[7:0]);
    if (en && (idx < len + 2)) begin
        wire_q[idx] = wire_q[idx] ^ mask;
    end
    for (int i = 0; i < len; i++) begin
        rx_pay.push_back(wire_q[i]);
    end
    calc = crc16_bitwise(rx_pay);
    rx   = {wire_q[len], wire_q[len+1]};
    // a corrupted byte anywhere in the frame must be caught
    ok   = !(en && (mask != 8'h00) && (idx < len + 2));
    exp_calc_q.push_back(calc);
    exp_rx_q.push_back(rx);
    exp_ok_q.push_back(ok);
    if (ok) begin
        good_exp++;
    end else begin
        bad_exp++;
    end
endfunction

`endif

// File: test/tb_crc_link.sv
// self-checking testbench; injection settings change only between phases while the link is idle
`timescale 1ns/1ns
`include "crc_defines.svh"

module tb_crc_link;

    logic        clk;
    logic        rst_n;
    logic        in_valid, in_ready, in_last;
    logic [7:0]  in_data;
    logic        status_valid, status_ready, status_crc_ok;
    logic [15:0] status_calc_crc, status_rx_crc;
    logic        reg_we;
    logic [2:0]  reg_addr;
    logic [15:0] reg_wdata, reg_rdata;

    integer      seed = 43603;
    int          errors = 0;
    int          checks = 0;
    logic        timed_out = 1'b0;

    `include "crc_ref_model.svh"

    crc_link_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_data         (in_data),
        .in_last         (in_last),
        .status_valid    (status_valid),
        .status_ready    (status_ready),
        .status_crc_ok   (status_crc_ok),
        .status_calc_crc (status_calc_crc),
        .status_rx_crc   (status_rx_crc),
        .reg_we          (reg_we),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata)
    );

    always #2 clk = ~clk;

    task automatic compare_val(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // all drive tasks start and end 1 ns after a rising edge
    task automatic write_reg(input logic [2:0] addr, input logic [15:0] val);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = val;
        @(posedge clk);
        #1;
        reg_we = 1'b0;
    endtask

    task automatic expect_reg(input logic [2:0] addr, input logic [15:0] exp, input string name);
        reg_addr = addr;
        #1;
        compare_val(name, reg_rdata, exp);
        @(posedge clk);
        #1;
    endtask

    task automatic send_frames(input int nframes);
        int pos;
        int wait_cnt;
        pos = 0;
        for (int f = 0; f < nframes && !timed_out; f++) begin
            for (int b = 0; b < len_q[f] && !timed_out; b++) begin
                in_valid = 1'b1;
                in_data  = pay_q[pos];
                in_last  = (b == len_q[f] - 1);
                pos++;
                wait_cnt = 0;
                @(negedge clk);
                while (!in_ready && wait_cnt < 200) begin
                    wait_cnt++;
                    @(negedge clk);
                end
                if (!in_ready) begin
                    $display("timeout: in_ready stayed low in frame %0d", f);
                    timed_out = 1'b1;
                end
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // random back-pressure where a status counts when valid and ready meet at the edge
    task automatic collect_statuses(input int nframes);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < nframes && !timed_out) begin
            status_ready = ({$random(seed)} % 4) != 0;
            @(negedge clk);
            if (status_valid && status_ready) begin
                compare_val("status_calc_crc", status_calc_crc, exp_calc_q.pop_front());
                compare_val("status_rx_crc", status_rx_crc, exp_rx_q.pop_front());
                compare_val("status_crc_ok", status_crc_ok, exp_ok_q.pop_front());
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > 500) begin
                    $display("timeout: no status after %0d of %0d frames", got, nframes);
                    timed_out = 1'b1;
                end
            end
            @(posedge clk);
            #1;
        end
        status_ready = 1'b0;
    endtask

    task automatic run_phase(input int ph, input logic en, input logic [7:0] idx,
                             input logic [7:0] mask, input int nframes);
        logic [7:0] frame [$];
        logic [7:0] rb;
        int         len;
        int         err0;
        err0 = errors;
        pay_q.delete();
        len_q.delete();
        write_reg(`REG_CTRL, {15'd0, en});
        write_reg(`REG_INJ_IDX, {8'd0, idx});
        write_reg(`REG_INJ_MASK, {8'd0, mask});
        for (int f = 0; f < nframes; f++) begin
            frame.delete();
            len = 1 + {$random(seed)} % 16;
            for (int b = 0; b < len; b++) begin
                rb = $random(seed);
                frame.push_back(rb);
                pay_q.push_back(rb);
            end
            len_q.push_back(len);
            predict_frame(frame, en, idx, mask);
        end
        fork
            send_frames(nframes);
            collect_statuses(nframes);
        join
        // nothing extra may follow the last frame
        repeat (3) @(negedge clk);
        compare_val("status_valid", status_valid, 0);
        @(posedge clk);
        #1;
        $display("phase %0d: %0d frames, enable %0d index %0d mask 0x%02h, %0d errors",
                 ph, nframes, en, idx, mask, errors - err0);
    endtask

    initial begin
        logic [7:0] idx;
        logic [7:0] mask;
        int         wait_cnt;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = 8'h00;
        in_last      = 1'b0;
        status_ready = 1'b0;
        reg_we       = 1'b0;
        reg_addr     = 3'd0;
        reg_wdata    = 16'h0000;
        repeat (3) @(posedge clk);
        #1;
        compare_val("in_ready", in_ready, 0);
        compare_val("status_valid", status_valid, 0);
        rst_n = 1'b1;
        @(negedge clk);
        compare_val("in_ready", in_ready, 0);
        wait_cnt = 0;
        while (!in_ready && wait_cnt < 20) begin
            wait_cnt++;
            @(negedge clk);
        end
        if (!in_ready) begin
            $display("timeout: in_ready never rose after reset");
            timed_out = 1'b1;
        end
        @(posedge clk);
        #1;
        expect_reg(`REG_CTRL, 16'h0, "reg_ctrl");
        expect_reg(`REG_INJ_IDX, 16'h0, "reg_inj_idx");
        expect_reg(`REG_INJ_MASK, 16'h0, "reg_inj_mask");
        expect_reg(`REG_GOOD_CNT, 16'h0, "reg_good_cnt");
        expect_reg(`REG_BAD_CNT, 16'h0, "reg_bad_cnt");
        $display("reset: %0d errors", errors);

        if (!timed_out) begin
            run_phase(0, 1'b0, 8'd0, 8'd0, 24);
        end
        // index 3 lands in payload, CRC high, CRC low or past the end depending on length
        for (int p = 1; p <= 6 && !timed_out; p++) begin
            if (p == 1) begin
                idx = 8'd3;
            end else if (p == 6) begin
                idx = 8'd40;
            end else begin
                idx = 8'({$random(seed)} % 18);
            end
            mask = $random(seed);
            if (mask == 8'h00) begin
                mask = 8'h5a;
            end
            run_phase(p, 1'b1, idx, mask, 16);
        end

        expect_reg(`REG_GOOD_CNT, 16'(good_exp), "reg_good_cnt");
        expect_reg(`REG_BAD_CNT, 16'(bad_exp), "reg_bad_cnt");
        $display("checks %0d, errors %0d, good frames %0d, bad frames %0d",
                 checks, errors, good_exp, bad_exp);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
+incdir+test
design/crc_pkg.sv
design/byte_stream_if.sv
design/crc16_engine.sv
design/crc_tx_framer.sv
design/link_fault_injector.sv
design/crc_rx_checker.sv
design/crc_link_regs.sv
design/crc_link_top.sv
test/tb_crc_link.sv

// File: Bender.yml
package:
  name: crc_link

sources:
  - include_dirs:
      - design
    files:
      - design/crc_pkg.sv
      - design/byte_stream_if.sv
      - design/crc16_engine.sv
      - design/crc_tx_framer.sv
      - design/link_fault_injector.sv
      - design/crc_rx_checker.sv
      - design/crc_link_regs.sv
      - design/crc_link_top.sv
  - target: test
    include_dirs:
      - design
      - test
    files:
      - test/tb_crc_link.sv
